// ==== design/host_pkg.sv ====
`default_nettype none

package host_pkg;

    ////////////////////
    // host word sizes
    ////////////////////

    // one wire-in or wire-out word
    localparam int unsigned host_word_w = 16;
    // trigger strobe bus width
    localparam int unsigned trig_w = 16;

    ////////////////////
    // trigger bits
    ////////////////////

    localparam int unsigned trig_half_cnt = 0;
    localparam int unsigned trig_gain_syn = 6;
    // length and velocity share one bit
    localparam int unsigned trig_len_vel = 10;

    ////////////////////
    // wire-out addresses
    ////////////////////

    localparam logic [7:0] addr_drive_lo = 8'h20;
    localparam logic [7:0] addr_drive_hi = 8'h21;
    localparam logic [7:0] addr_sn_cnt_lo = 8'h24;
    localparam logic [7:0] addr_sn_cnt_hi = 8'h25;
    localparam logic [7:0] addr_mn_cnt_lo = 8'h26;
    localparam logic [7:0] addr_mn_cnt_hi = 8'h27;
    localparam logic [7:0] addr_len_lo = 8'h2C;
    localparam logic [7:0] addr_len_hi = 8'h2D;
    localparam logic [7:0] addr_vel_lo = 8'h2E;
    localparam logic [7:0] addr_vel_hi = 8'h2F;

endpackage

`default_nettype wire

// ==== design/model_pkg.sv ====
`default_nettype none

package model_pkg;

    ////////////////////
    // value widths
    ////////////////////

    // every model value is one 32-bit word
    localparam int unsigned value_w = 32;

    ////////////////////
    // reset defaults
    ////////////////////

    // tick period of 10 cycles
    localparam logic [value_w-1:0] half_cnt_rst = 32'd9;
    // unity synapse gain
    localparam logic [value_w-1:0] gain_syn_rst = 32'd1;
    // 0.9 as ieee single
    localparam logic [value_w-1:0] len_f0_rst = 32'h3F66_6666;
    // 0.0
    localparam logic [value_w-1:0] vel_rst = 32'h0000_0000;
    // 1.0 as ieee single
    localparam logic [value_w-1:0] len_sample_rst = 32'h3F80_0000;

    ////////////////////
    // readout word views
    ////////////////////

    // one result word, seen whole or as two host halves
    typedef union packed {
        logic [value_w-1:0] whole;
        struct packed {
            logic [value_w/2-1:0] hi;
            logic [value_w/2-1:0] lo;
        } half;
    } readout_word_u;

endpackage

`default_nettype wire

// ==== design/host_config_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module host_config_regs (
    input  wire                                     ep50trig,
    input  wire                                     reset_sim,
    input  wire        [host_pkg::trig_w-1:0]       i_trig,
    input  wire        [host_pkg::host_word_w-1:0]  i_word01,
    input  wire        [host_pkg::host_word_w-1:0]  i_word02,
    input  wire        [host_pkg::host_word_w-1:0]  i_word03,
    input  wire        [host_pkg::host_word_w-1:0]  i_word04,
    input  wire                                     i_sim_tick,
    output logic       [model_pkg::value_w-1:0]     o_half_cnt,
    output logic signed [model_pkg::value_w-1:0]    o_gain_syn,
    output logic       [model_pkg::value_w-1:0]     o_len_sample,
    output logic       [model_pkg::value_w-1:0]     o_velocity
);

    // length from host, before the tick sample
    logic [model_pkg::value_w-1:0] len_f0;

    ////////////////////
    // single-word registers
    ////////////////////

    // tick divider half-count
    always_ff @(posedge ep50trig or posedge reset_sim)
    begin
        if (reset_sim)
            o_half_cnt <= model_pkg::half_cnt_rst;
        else if (i_trig[host_pkg::trig_half_cnt])
            o_half_cnt <= {i_word02, i_word01};
    end

    // signed synapse gain
    always_ff @(posedge ep50trig or posedge reset_sim)
    begin
        if (reset_sim)
            o_gain_syn <= model_pkg::gain_syn_rst;
        else if (i_trig[host_pkg::trig_gain_syn])
            o_gain_syn <= {i_word02, i_word01};
    end

    ////////////////////
    // length and velocity
    ////////////////////

    // loaded as one pair, velocity words swapped in order
    always_ff @(posedge ep50trig or posedge reset_sim)
    begin
        if (reset_sim)
        begin
            len_f0     <= model_pkg::len_f0_rst;
            o_velocity <= model_pkg::vel_rst;
        end
        else if (i_trig[host_pkg::trig_len_vel])
        begin
            len_f0     <= {i_word02, i_word01};
            o_velocity <= {i_word03, i_word04};
        end
    end

    // length seen by the loop, refreshed once per tick
    // holds 1.0 until the first tick
    always_ff @(posedge ep50trig or posedge reset_sim)
    begin
        if (reset_sim)
            o_len_sample <= model_pkg::len_sample_rst;
        else if (i_sim_tick)
            o_len_sample <= len_f0;
    end

endmodule

`default_nettype wire

// ==== design/sim_tick_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module sim_tick_gen (
    input  wire                                ep50trig,
    input  wire                                reset_sim,
    input  wire  [model_pkg::value_w-1:0]      i_half_cnt,
    output logic                               o_sim_tick
);

    // cycles since the last tick
    logic [model_pkg::value_w-1:0] cycle_cnt;

    // tick when count reaches or passes half-count
    // a lowered half-count fires at once
    assign o_sim_tick = (cycle_cnt >= i_half_cnt);

    // free-running, restarts from 0 after each tick
    always_ff @(posedge ep50trig or posedge reset_sim)
    begin
        if (reset_sim)
            cycle_cnt <= '0;
        else if (o_sim_tick)
            cycle_cnt <= '0;
        else
            cycle_cnt <= cycle_cnt + 1'b1;
    end

endmodule

`default_nettype wire

// ==== design/spike_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module spike_counter (
    input  wire                                ep50trig,
    input  wire                                reset_sim,
    input  wire                                i_spike,
    input  wire                                i_sim_tick,
    output logic [model_pkg::value_w-1:0]      o_count
);

    // spikes so far in the open window
    logic [model_pkg::value_w-1:0] run_cnt;
    // running count including this cycle's spike
    logic [model_pkg::value_w-1:0] run_next;

    assign run_next = run_cnt + {{(model_pkg::value_w-1){1'b0}}, i_spike};

    ////////////////////
    // window bookkeeping
    ////////////////////

    // tick closes the window, spike in tick cycle counts toward it
    always_ff @(posedge ep50trig or posedge reset_sim)
    begin
        if (reset_sim)
        begin
            run_cnt <= '0;
            o_count <= '0;
        end
        else if (i_sim_tick)
        begin
            run_cnt <= '0;
            o_count <= run_next;
        end
        else
            run_cnt <= run_next;
    end

endmodule

`default_nettype wire

// ==== design/synaptic_drive.sv ====
`timescale 1ns/1ps
`default_nettype none

module synaptic_drive (
    input  wire                                   ep50trig,
    input  wire                                   reset_sim,
    input  wire signed  [model_pkg::value_w-1:0]  i_cur_spinal,
    input  wire signed  [model_pkg::value_w-1:0]  i_cur_cn_end,
    input  wire signed  [model_pkg::value_w-1:0]  i_gain_syn,
    output logic signed [model_pkg::value_w-1:0]  o_drive
);

    // spinal plus transcortical, wraps at 32 bits
    logic signed [model_pkg::value_w-1:0]   cur_sum;
    // full signed product
    logic signed [2*model_pkg::value_w-1:0] cur_scaled;

    assign cur_sum    = i_cur_spinal + i_cur_cn_end;
    assign cur_scaled = cur_sum * i_gain_syn;

    // motor-neuron input current, low word only
    always_ff @(posedge ep50trig or posedge reset_sim)
    begin
        if (reset_sim)
            o_drive <= '0;
        else
            o_drive <= cur_scaled[model_pkg::value_w-1:0];
    end

endmodule

`default_nettype wire

// ==== design/readout_mux.sv ====
`timescale 1ns/1ps
`default_nettype none

module readout_mux (
    input  wire                                   ep50trig,
    input  wire                                   reset_sim,
    input  wire  [7:0]                            i_rd_addr,
    input  wire  [model_pkg::value_w-1:0]         i_drive,
    input  wire  [model_pkg::value_w-1:0]         i_sn_count,
    input  wire  [model_pkg::value_w-1:0]         i_mn_count,
    input  wire  [model_pkg::value_w-1:0]         i_len_sample,
    input  wire  [model_pkg::value_w-1:0]         i_velocity,
    output logic [host_pkg::host_word_w-1:0]      o_rd_data
);

    // chosen result word read as halves below
    model_pkg::readout_word_u sel_word;
    // upper half wanted
    logic sel_hi;

    ////////////////////
    // address decode
    ////////////////////

    // odd endpoint of each pair is the upper half
    always_comb
    begin
        sel_hi = i_rd_addr[0];
        case (i_rd_addr)
            host_pkg::addr_drive_lo, host_pkg::addr_drive_hi:
                sel_word.whole = i_drive;
            host_pkg::addr_sn_cnt_lo, host_pkg::addr_sn_cnt_hi:
                sel_word.whole = i_sn_count;
            host_pkg::addr_mn_cnt_lo, host_pkg::addr_mn_cnt_hi:
                sel_word.whole = i_mn_count;
            host_pkg::addr_len_lo, host_pkg::addr_len_hi:
                sel_word.whole = i_len_sample;
            host_pkg::addr_vel_lo, host_pkg::addr_vel_hi:
                sel_word.whole = i_velocity;
            // unlisted address reads 0
            default:
                sel_word.whole = '0;
        endcase
    end

    // one cycle from address to data
    always_ff @(posedge ep50trig or posedge reset_sim)
    begin
        if (reset_sim)
            o_rd_data <= '0;
        else if (sel_hi)
            o_rd_data <= sel_word.half.hi;
        else
            o_rd_data <= sel_word.half.lo;
    end

endmodule

`default_nettype wire

// ==== design/reflex_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module reflex_top (
    input  wire                ep50trig,
    input  wire                reset_sim,
    input  wire         [15:0] i_trig,
    input  wire         [15:0] i_word01,
    input  wire         [15:0] i_word02,
    input  wire         [15:0] i_word03,
    input  wire         [15:0] i_word04,
    input  wire                i_sn_spike,
    input  wire                i_mn_spike,
    input  wire signed  [31:0] i_cur_spinal,
    input  wire signed  [31:0] i_cur_cn_end,
    input  wire         [7:0]  i_rd_addr,
    output wire         [15:0] o_rd_data,
    output wire                o_sim_tick,
    output wire signed  [31:0] o_drive
);

    // configuration to the datapath
    wire        [31:0] half_cnt;
    wire signed [31:0] gain_syn;
    wire        [31:0] len_sample;
    wire        [31:0] velocity;
    // per-window spike totals
    wire        [31:0] sn_count;
    wire        [31:0] mn_count;

    ////////////////////
    // host configuration
    ////////////////////

    host_config_regs cfg_regs (
        .ep50trig     (ep50trig),
        .reset_sim    (reset_sim),
        .i_trig       (i_trig),
        .i_word01     (i_word01),
        .i_word02     (i_word02),
        .i_word03     (i_word03),
        .i_word04     (i_word04),
        .i_sim_tick   (o_sim_tick),
        .o_half_cnt   (half_cnt),
        .o_gain_syn   (gain_syn),
        .o_len_sample (len_sample),
        .o_velocity   (velocity)
    );

    // simulation tick, stands in for the slow clock
    sim_tick_gen tick_gen (
        .ep50trig   (ep50trig),
        .reset_sim  (reset_sim),
        .i_half_cnt (half_cnt),
        .o_sim_tick (o_sim_tick)
    );

    ////////////////////
    // spike counting
    ////////////////////

    // sensory neuron
    spike_counter sn_counter (
        .ep50trig   (ep50trig),
        .reset_sim  (reset_sim),
        .i_spike    (i_sn_spike),
        .i_sim_tick (o_sim_tick),
        .o_count    (sn_count)
    );

    // motor neuron
    spike_counter mn_counter (
        .ep50trig   (ep50trig),
        .reset_sim  (reset_sim),
        .i_spike    (i_mn_spike),
        .i_sim_tick (o_sim_tick),
        .o_count    (mn_count)
    );

    // gain-scaled synaptic current
    synaptic_drive drive_stage (
        .ep50trig     (ep50trig),
        .reset_sim    (reset_sim),
        .i_cur_spinal (i_cur_spinal),
        .i_cur_cn_end (i_cur_cn_end),
        .i_gain_syn   (gain_syn),
        .o_drive      (o_drive)
    );

    ////////////////////
    // wire-out readback
    ////////////////////

    readout_mux rd_mux (
        .ep50trig     (ep50trig),
        .reset_sim    (reset_sim),
        .i_rd_addr    (i_rd_addr),
        .i_drive      (o_drive),
        .i_sn_count   (sn_count),
        .i_mn_count   (mn_count),
        .i_len_sample (len_sample),
        .i_velocity   (velocity),
        .o_rd_data    (o_rd_data)
    );

endmodule

`default_nettype wire

// ==== tests/tb_reflex_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_reflex_top;

    localparam int clk_period = 10;
    localparam int reset_cycles = 2;
    localparam logic [15:0] lfsr_seed = 16'd52596;
    // default half-count of 9 gives a 10-cycle tick period
    localparam int first_tick_cycles = 10;
    // spare cycles on top of the worked-out run length
    localparam int margin_cycles = 200;

    logic               ep50trig;
    logic               reset_sim;
    logic        [15:0] i_trig;
    logic        [15:0] i_word01;
    logic        [15:0] i_word02;
    logic        [15:0] i_word03;
    logic        [15:0] i_word04;
    logic               i_sn_spike;
    logic               i_mn_spike;
    logic signed [31:0] i_cur_spinal;
    logic signed [31:0] i_cur_cn_end;
    logic        [7:0]  i_rd_addr;
    wire         [15:0] o_rd_data;
    wire                o_sim_tick;
    wire  signed [31:0] o_drive;

    int          errors;
    int          checks;
    // watchdog length in cycles, valid once budget_ready is set
    int          budget;
    logic        budget_ready;
    logic [15:0] lfsr;
    // half-count the dut should hold, tracked from the trig lines
    logic [31:0] half_model;
    string       lines[$];

    reflex_top dut0 (
        .ep50trig     (ep50trig),
        .reset_sim    (reset_sim),
        .i_trig       (i_trig),
        .i_word01     (i_word01),
        .i_word02     (i_word02),
        .i_word03     (i_word03),
        .i_word04     (i_word04),
        .i_sn_spike   (i_sn_spike),
        .i_mn_spike   (i_mn_spike),
        .i_cur_spinal (i_cur_spinal),
        .i_cur_cn_end (i_cur_cn_end),
        .i_rd_addr    (i_rd_addr),
        .o_rd_data    (o_rd_data),
        .o_sim_tick   (o_sim_tick),
        .o_drive      (o_drive)
    );

    initial
        ep50trig = 1'b0;
    always
        #(clk_period / 2) ep50trig = ~ep50trig;

    ////////////////////
    // helpers
    ////////////////////

    task automatic check_val(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("mismatch %s expected %h actual %h", name, expected, actual);
        end
    endtask

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    // empty for blank and comment lines
    function automatic string command_of(input string line);
        string cmd;
        cmd = "";
        if (line.len() > 0 && line[0] != "#")
            void'($sscanf(line, "%s", cmd));
        return cmd;
    endfunction

    // entered and left on a falling edge
    task automatic read_word(input string name, input logic [7:0] addr,
                             input logic [15:0] expected);
        i_rd_addr = addr;
        @(negedge ep50trig);
        check_val(name, expected, o_rd_data);
    endtask

    task automatic load_trig(input int bit_pos, input logic [15:0] w1,
                             input logic [15:0] w2, input logic [15:0] w3,
                             input logic [15:0] w4);
        i_trig   = 16'h0001 << bit_pos;
        i_word01 = w1;
        i_word02 = w2;
        i_word03 = w3;
        i_word04 = w4;
        if (bit_pos == 0)
            half_model = {w2, w1};
        @(negedge ep50trig);
        // strobe lasts one cycle
        i_trig = '0;
    endtask

    // registered product seen one cycle after the currents
    task automatic check_drive(input string name, input logic [31:0] spinal,
                               input logic [31:0] cn_end, input logic [31:0] expected);
        i_cur_spinal = spinal;
        i_cur_cn_end = cn_end;
        @(negedge ep50trig);
        check_val(name, expected, o_drive);
    endtask

    ////////////////////
    // spike windows
    ////////////////////

    // first tick only syncs, then n_win windows are counted and read back
    task automatic run_windows(input string name, input int n_win);
        int          win;
        int          since;
        int          sn_run;
        int          mn_run;
        logic        tick;
        logic [7:0]  rd_addrs [4];
        logic [15:0] rd_exp [4];
        rd_addrs[0] = host_pkg::addr_sn_cnt_lo;
        rd_addrs[1] = host_pkg::addr_sn_cnt_hi;
        rd_addrs[2] = host_pkg::addr_mn_cnt_lo;
        rd_addrs[3] = host_pkg::addr_mn_cnt_hi;
        win    = -1;
        since  = 0;
        sn_run = 0;
        mn_run = 0;
        while (win < n_win || since < 5)
        begin
            @(negedge ep50trig);
            since++;
            tick = o_sim_tick;
            // totals of the closed window, data one cycle behind address
            if (win >= 1 && since >= 2 && since <= 5)
                check_val($sformatf("%s window %0d addr %h", name, win, rd_addrs[since-2]),
                          rd_exp[since-2], o_rd_data);
            if (win >= 1 && since >= 1 && since <= 4)
                i_rd_addr = rd_addrs[since-1];
            // one lfsr step per spike bit, sensory then motor
            lfsr       = lfsr_step(lfsr);
            i_sn_spike = lfsr[0];
            lfsr       = lfsr_step(lfsr);
            i_mn_spike = lfsr[0];
            // spike in the tick cycle still belongs to the closing window
            if (win >= 0 && win < n_win)
            begin
                sn_run += i_sn_spike;
                mn_run += i_mn_spike;
            end
            if (tick && win < n_win)
            begin
                if (win >= 0)
                    check_val($sformatf("%s window %0d period", name, win + 1),
                              half_model + 1, since);
                rd_exp[0] = sn_run[15:0];
                rd_exp[1] = sn_run[31:16];
                rd_exp[2] = mn_run[15:0];
                rd_exp[3] = mn_run[31:16];
                sn_run = 0;
                mn_run = 0;
                win++;
                since = 0;
            end
        end
        i_sn_spike = 1'b0;
        i_mn_spike = 1'b0;
    endtask

    ////////////////////
    // first tick after reset
    ////////////////////

    initial
    begin : first_tick_check
        int n;
        @(negedge reset_sim);
        // release cycle is cycle one
        n = 1;
        while (o_sim_tick !== 1'b1)
        begin
            @(negedge ep50trig);
            n++;
        end
        check_val("first tick after reset", first_tick_cycles, n);
    end

    initial
    begin : watchdog
        wait (budget_ready === 1'b1);
        #(budget * clk_period);
        $display("timeout, stimulus not finished after %0d cycles", budget);
        $display("errors: %0d of %0d checks failed", errors, checks);
        $display("Errors found");
        $finish;
    end

    ////////////////////
    // main sequence
    ////////////////////

    initial
    begin : main_run
        int          fd;
        int          bit_pos;
        int          n_win;
        int          max_win;
        int          weight;
        string       line;
        string       cmd;
        string       name;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] d;
        reset_sim    = 1'b1;
        i_trig       = '0;
        i_word01     = '0;
        i_word02     = '0;
        i_word03     = '0;
        i_word04     = '0;
        i_sn_spike   = 1'b0;
        i_mn_spike   = 1'b0;
        i_cur_spinal = '0;
        i_cur_cn_end = '0;
        i_rd_addr    = '0;
        errors       = 0;
        checks       = 0;
        budget_ready = 1'b0;
        lfsr         = lfsr_seed;
        half_model   = first_tick_cycles - 1;
        fd = $fopen("tests/reflex_stim.txt", "r");
        if (fd == 0)
        begin
            $display("cannot open the stimulus file tests/reflex_stim.txt");
            errors++;
        end
        else
        begin
            while (!$feof(fd))
            begin
                if ($fgets(line, fd) > 0)
                    lines.push_back(line);
            end
            $fclose(fd);
        end
        // run length from the command count and the longest window
        max_win = first_tick_cycles;
        weight  = 0;
        foreach (lines[i])
        begin
            cmd = command_of(lines[i]);
            if (cmd == "trig")
            begin
                void'($sscanf(lines[i], "%s %d %h %h", cmd, bit_pos, a, b));
                if (bit_pos == 0 && {b[15:0], a[15:0]} + 1 > max_win)
                    max_win = {b[15:0], a[15:0]} + 1;
            end
            if (cmd == "spikes")
            begin
                void'($sscanf(lines[i], "%s %d", cmd, n_win));
                weight += n_win + 2;
            end
            else if (cmd != "")
                weight++;
        end
        budget       = weight * max_win + margin_cycles;
        budget_ready = 1'b1;
        repeat (reset_cycles) @(negedge ep50trig);
        reset_sim = 1'b0;
        foreach (lines[i])
        begin
            cmd  = command_of(lines[i]);
            name = $sformatf("line %0d %s", i + 1, cmd);
            if (cmd == "trig")
            begin
                void'($sscanf(lines[i], "%s %d %h %h %h %h", cmd, bit_pos, a, b, c, d));
                load_trig(bit_pos, a[15:0], b[15:0], c[15:0], d[15:0]);
            end
            else if (cmd == "spikes")
            begin
                void'($sscanf(lines[i], "%s %d", cmd, n_win));
                run_windows(name, n_win);
            end
            else if (cmd == "drive")
            begin
                void'($sscanf(lines[i], "%s %h %h %h", cmd, a, b, c));
                check_drive(name, a, b, c);
            end
            else if (cmd == "read")
            begin
                void'($sscanf(lines[i], "%s %h %h", cmd, a, b));
                read_word(name, a[7:0], b[15:0]);
            end
            else if (cmd != "")
            begin
                $display("unknown command on line %0d: %s", i + 1, cmd);
                errors++;
            end
        end
        @(negedge ep50trig);
        if (checks == 0)
        begin
            $display("no checks were run");
            errors++;
        end
        $display("errors: %0d of %0d checks failed", errors, checks);
        if (errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/reflex_stim.txt ====
# bit and windows in decimal, all else hex: trig <bit> <w01> <w02> <w03> <w04>
# spikes <windows> / drive <spinal> <cn_end> <expected drive> / read <addr> <expected data>
read 2C 0000
read 2D 3F80
read 2E 0000
read 2F 0000
spikes 3
trig 0 0005 0000 0000 0000
spikes 4
trig 0 000B 0000 0000 0000
spikes 2
trig 10 3333 3F33 4120 0000
read 2E 0000
read 2F 4120
spikes 1
read 2C 3333
read 2D 3F33
trig 6 0003 0000 0000 0000
drive 00000064 000000C8 00000384
read 20 0384
read 21 0000
drive 7FFFFFFF 00000003 80000006
read 20 0006
read 21 8000
trig 6 FFFE FFFF 0000 0000
drive 00000010 00000005 FFFFFFD6
read 21 FFFF
drive 7FFFFFFF 00000003 FFFFFFFC
read 20 FFFC
read 22 0000

// ==== sim.f ====
design/host_pkg.sv
design/model_pkg.sv
design/host_config_regs.sv
design/sim_tick_gen.sv
design/spike_counter.sv
design/synaptic_drive.sv
design/readout_mux.sv
design/reflex_top.sv
tests/tb_reflex_top.sv

// ==== Bender.yml ====
package:
  name: reflex_core

sources:
  - files:
      - design/host_pkg.sv
      - design/model_pkg.sv
      - design/host_config_regs.sv
      - design/sim_tick_gen.sv
      - design/spike_counter.sv
      - design/synaptic_drive.sv
      - design/readout_mux.sv
      - design/reflex_top.sv
  - target: test
    files:
      - tests/tb_reflex_top.sv
